/* rtl/dfa_context.sv */
`timescale 1ns/1ps

module dfa_context #(
  parameter int          PAT_LEN = 4,
  parameter logic [63:0] PATTERN = {"HELO", 32'h0},
  parameter int          CAT     = 0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  sess_regex_pkg::ctx_ctrl_t   ctx_ctrl,
  input  sess_regex_pkg::char_beat_t  char_beat,
  output sess_regex_pkg::count_t      count,
  output logic                        fired,
  output logic                        eop_seen
);

  localparam int NUM_STREAMS = 2 ** $bits(sess_regex_pkg::stream_id_t);

  // Saved state per stream
  sess_regex_pkg::dfa_state_t state_mem [NUM_STREAMS];

  // Restore stage
  logic                       state_in_vld;
  sess_regex_pkg::dfa_state_t state_in;
  logic                       new_q;

  // Registered DFA inputs
  logic                       state_in_vld_r;
  sess_regex_pkg::dfa_state_t state_in_r;
  sess_regex_pkg::char_beat_t beat_r;

  // Registered DFA outputs, state_out_r is the running state
  sess_regex_pkg::dfa_state_t state_out_r;
  logic                       accept_out_r;
  sess_regex_pkg::dfa_state_t state_out;
  logic                       accept_out;
  sess_regex_pkg::dfa_state_t dfa_cur;

  logic                       speculative_match;
  logic                       enable;

  assign enable = ctx_ctrl.enable_mask[CAT];

  // Restore the saved word for a known stream, start from zero otherwise
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld <= 1'b0;
      new_q        <= 1'b0;
    end
    else
    begin
      state_in_vld <= ctx_ctrl.load_state;
      if (ctx_ctrl.load_state)
        new_q <= ctx_ctrl.new_stream;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ctx_ctrl.load_state)
      state_in <= ctx_ctrl.new_stream ? '0 : state_mem[ctx_ctrl.stream];
  end

  // Save at eop when enabled; a new stream skipped here still gets a clean slot
  always_ff @(posedge clk)
  begin
    if (ctx_ctrl.eop && enable)
      state_mem[ctx_ctrl.stream] <= state_out_r;
    else if (ctx_ctrl.eop && new_q)
      state_mem[ctx_ctrl.stream] <= '0;
  end

  // All DFA inputs and outputs registered for timing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld_r <= 1'b0;
      beat_r         <= '0;
      state_out_r    <= '0;
      accept_out_r   <= 1'b0;
    end
    else
    begin
      state_in_vld_r <= state_in_vld;
      beat_r         <= char_beat;
      state_out_r    <= state_out;
      accept_out_r   <= accept_out;
    end
  end

  always_ff @(posedge clk)
  begin
    state_in_r <= state_in;
  end

  // Restored word replaces the running state for the first character
  assign dfa_cur = state_in_vld_r ? state_in_r : state_out_r;

  literal_dfa #(
    .PAT_LEN (PAT_LEN),
    .PATTERN (PATTERN)
  ) literal_dfa_i (
    .state_in     (dfa_cur),
    .state_in_vld (state_in_vld_r),
    .ch           (beat_r.ch),
    .ch_vld       (beat_r.vld),
    .next_state   (state_out),
    .accept       (accept_out)
  );

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      speculative_match <= 1'b0;
      count             <= '0;
      fired             <= 1'b0;
      eop_seen          <= 1'b0;
    end
    else
    begin
      eop_seen <= ctx_ctrl.eop;
      // Flag is per packet
      if (ctx_ctrl.load_state)
        speculative_match <= 1'b0;
      if (accept_out_r)
        speculative_match <= 1'b1;
      if (ctx_ctrl.eop)
      begin
        if (enable)
        begin
          count <= count + sess_regex_pkg::count_t'(speculative_match);
          fired <= speculative_match;
        end
        else
        begin
          // Category off for this stream
          speculative_match <= 1'b0;
          fired             <= 1'b0;
        end
      end
    end
  end

  a_eop_vs_load : assert property (
    @(posedge clk) disable iff (!rst_n) !(ctx_ctrl.eop && ctx_ctrl.load_state)
  ) else $error("category %0d eop collided with load_state", CAT);

endmodule

/* rtl/literal_dfa.sv */
`timescale 1ns/1ps

module literal_dfa #(
  parameter int          PAT_LEN = 4,
  parameter logic [63:0] PATTERN = {"HELO", 32'h0}
) (
  input  sess_regex_pkg::dfa_state_t  state_in,
  input  logic                        state_in_vld,
  input  sess_regex_pkg::char_t       ch,
  input  logic                        ch_vld,
  output sess_regex_pkg::dfa_state_t  next_state,
  output logic                        accept
);

  // Character i of the literal, first one in the high byte
  function automatic sess_regex_pkg::char_t pat_char(input int i);
    return PATTERN[63 - 8*i -: 8];
  endfunction

  // Bit b*8+k-1 set when prefix k-1 is a suffix of prefix b,
  // so matched length b can extend to k on character k-1
  function automatic logic [63:0] build_border();
    logic [63:0] tbl;
    logic        ok;
    tbl = '0;
    for (int b = 0; b < PAT_LEN; b++)
    begin
      for (int k = 1; k <= b + 1; k++)
      begin
        ok = 1'b1;
        for (int j = 0; j < k - 1; j++)
        begin
          if (pat_char(j) != pat_char(b - k + 1 + j))
            ok = 1'b0;
        end
        tbl[b*8 + k - 1] = ok;
      end
    end
    return tbl;
  endfunction

  // Longest proper border of the whole literal
  function automatic int full_border();
    int   best;
    logic ok;
    best = 0;
    for (int l = 1; l < PAT_LEN; l++)
    begin
      ok = 1'b1;
      for (int j = 0; j < l; j++)
      begin
        if (pat_char(j) != pat_char(PAT_LEN - l + j))
          ok = 1'b0;
      end
      if (ok)
        best = l;
    end
    return best;
  endfunction

  localparam logic [63:0] BORDER_OK = build_border();
  localparam int          FALLBACK  = full_border();

  sess_regex_pkg::dfa_state_t base;
  logic [3:0]                 len_nxt;

  always_comb
  begin
    base = state_in;
    // Restored word beyond the literal is treated as no progress
    if (state_in_vld && state_in >= sess_regex_pkg::dfa_state_t'(PAT_LEN))
      base = '0;
    // Ascending scan leaves the longest prefix that still matches
    len_nxt = '0;
    for (int k = 1; k <= PAT_LEN; k++)
    begin
      if (k <= int'(base) + 1 && BORDER_OK[int'(base[2:0])*8 + k - 1] &&
          pat_char(k - 1) == ch)
        len_nxt = 4'(k);
    end
    if (!ch_vld)
    begin
      next_state = base;
      accept     = 1'b0;
    end
    else if (int'(len_nxt) == PAT_LEN)
    begin
      // Full hit, keep the overlap for the next one
      next_state = sess_regex_pkg::dfa_state_t'(FALLBACK);
      accept     = 1'b1;
    end
    else
    begin
      next_state = sess_regex_pkg::dfa_state_t'(len_nxt);
      accept     = 1'b0;
    end
  end

endmodule

/* rtl/scan_ctrl.sv */
`timescale 1ns/1ps

module scan_ctrl #(
  parameter int NUM_CAT = 2
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  sess_regex_pkg::pkt_in_t     pkt_in,
  output logic                        lookup_req,
  output sess_regex_pkg::stream_id_t  lookup_stream,
  input  logic                        seen,
  input  sess_regex_pkg::cat_mask_t   mask,
  output logic                        mark_seen,
  output sess_regex_pkg::ctx_ctrl_t   ctx_ctrl,
  output sess_regex_pkg::char_beat_t  char_beat,
  output logic                        pkt_done
);

  // Only categories that exist may be enabled
  localparam sess_regex_pkg::cat_mask_t CAT_VALID =
    sess_regex_pkg::cat_mask_t'((1 << NUM_CAT) - 1);

  sess_regex_pkg::ctrl_state_e state_q;
  sess_regex_pkg::ctrl_state_e state_d;

  sess_regex_pkg::stream_id_t  stream_q;
  sess_regex_pkg::cat_mask_t   mask_q;
  logic                        load_q;
  logic                        in_pkt;
  logic                        in_eop;

  // Two stage character delay
  sess_regex_pkg::char_beat_t  beat_d1;
  sess_regex_pkg::char_beat_t  beat_d2;

  // Bit 4 is the context eop, bit 5 the done pulse
  logic [5:0]                  eop_pipe;

  // Characters count only between sop and eop
  assign in_pkt = (state_q == sess_regex_pkg::IDLE && pkt_in.sop) ||
                  state_q == sess_regex_pkg::LOOKUP ||
                  state_q == sess_regex_pkg::STREAM;
  assign in_eop = in_pkt && pkt_in.vld && pkt_in.eop;

  // Lookup goes out on the sop cycle itself
  assign lookup_stream = pkt_in.stream;

  always_comb
  begin
    state_d    = state_q;
    lookup_req = 1'b0;
    case (state_q)
      sess_regex_pkg::IDLE:
        if (pkt_in.sop)
        begin
          lookup_req = 1'b1;
          state_d    = sess_regex_pkg::LOOKUP;
        end
      sess_regex_pkg::LOOKUP:
        // A short packet may already have ended on the sop cycle
        if (eop_pipe[0] || in_eop)
          state_d = sess_regex_pkg::DRAIN;
        else
          state_d = sess_regex_pkg::STREAM;
      sess_regex_pkg::STREAM:
        if (in_eop)
          state_d = sess_regex_pkg::DRAIN;
      sess_regex_pkg::DRAIN:
        if (eop_pipe[5])
          state_d = sess_regex_pkg::IDLE;
      default:
        state_d = sess_regex_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= sess_regex_pkg::IDLE;
      load_q   <= 1'b0;
      mask_q   <= '0;
      eop_pipe <= '0;
      beat_d1  <= '0;
      beat_d2  <= '0;
    end
    else
    begin
      state_q  <= state_d;
      // Table answer is back one cycle after sop
      load_q   <= state_q == sess_regex_pkg::IDLE && pkt_in.sop;
      if (state_q == sess_regex_pkg::LOOKUP)
        mask_q <= mask & CAT_VALID;
      eop_pipe <= {eop_pipe[4:0], in_eop};
      beat_d1  <= '{vld: in_pkt && pkt_in.vld, ch: pkt_in.ch};
      beat_d2  <= beat_d1;
    end
  end

  // Stream id held for the whole packet, including the drain
  always_ff @(posedge clk)
  begin
    if (state_q == sess_regex_pkg::IDLE && pkt_in.sop)
      stream_q <= pkt_in.stream;
  end

  assign ctx_ctrl.load_state  = load_q;
  assign ctx_ctrl.new_stream  = ~seen;
  assign ctx_ctrl.eop         = eop_pipe[4];
  assign ctx_ctrl.stream      = stream_q;
  assign ctx_ctrl.enable_mask = mask_q;

  assign char_beat = beat_d2;
  assign pkt_done  = eop_pipe[5];
  assign mark_seen = eop_pipe[5];

  // Spacing rule from the sender
  a_sop_spacing : assert property (
    @(posedge clk) disable iff (!rst_n)
    pkt_in.sop |-> !(state_q inside {sess_regex_pkg::STREAM, sess_regex_pkg::DRAIN})
  ) else $error("sop arrived before previous packet drained");

endmodule

/* rtl/sess_regex_pkg.sv */
package sess_regex_pkg;

  // One byte of SMTP session text
  typedef logic [7:0] char_t;

  // 64 interleaved TCP streams
  typedef logic [5:0] stream_id_t;

  // Saved DFA state word, same width as the hardware state memory
  typedef logic [10:0] dfa_state_t;

  // Packet match counter, wraps on overflow
  typedef logic [15:0] count_t;

  // Per-stream category enable bits, low NUM_CAT bits in use
  typedef logic [7:0] cat_mask_t;

  // Raw packet input strobes
  typedef struct packed {
    logic       sop;
    logic       eop;
    logic       vld;
    char_t      ch;
    stream_id_t stream;
  } pkt_in_t;

  // Character beat as seen by the DFA contexts
  typedef struct packed {
    logic  vld;
    char_t ch;
  } char_beat_t;

  // Aligned control from the controller to every context
  typedef struct packed {
    logic       load_state;
    logic       new_stream;
    logic       eop;
    stream_id_t stream;
    cat_mask_t  enable_mask;
  } ctx_ctrl_t;

  // Configuration write of one stream's enable mask
  typedef struct packed {
    logic       we;
    stream_id_t stream;
    cat_mask_t  mask;
  } cfg_wr_t;

  typedef enum logic [1:0] {IDLE, LOOKUP, STREAM, DRAIN} ctrl_state_e;

endpackage

/* rtl/sess_regex_scan_top.sv */
`timescale 1ns/1ps

module sess_regex_scan_top #(
  parameter int NUM_CAT = 2,
  parameter int PAT_LEN = 4,
  // Category 0 in the low word, first character in the high byte of each word
  parameter logic [NUM_CAT-1:0][63:0] PATTERNS = {{"RCPT", 32'h0}, {"HELO", 32'h0}}
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  sess_regex_pkg::pkt_in_t                  pkt_in,
  input  sess_regex_pkg::cfg_wr_t                  cfg,
  output sess_regex_pkg::count_t [NUM_CAT-1:0]     match_count,
  output logic                                     pkt_done,
  output logic [NUM_CAT-1:0]                       fired
);

  // Controller to stream table
  logic                        lookup_req;
  sess_regex_pkg::stream_id_t  lookup_stream;
  logic                        mark_seen;

  // Stream table back to the controller
  logic                        seen;
  sess_regex_pkg::cat_mask_t   mask;

  // Shared context control and character beat
  sess_regex_pkg::ctx_ctrl_t   ctx_ctrl;
  sess_regex_pkg::char_beat_t  char_beat;

  // One end-of-packet echo per context
  logic [NUM_CAT-1:0]          eop_seen;

  // Per-context flags, held from one eop to the next
  logic [NUM_CAT-1:0]          fired_q;

  scan_ctrl #(
    .NUM_CAT (NUM_CAT)
  ) scan_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pkt_in        (pkt_in),
    .lookup_req    (lookup_req),
    .lookup_stream (lookup_stream),
    .seen          (seen),
    .mask          (mask),
    .mark_seen     (mark_seen),
    .ctx_ctrl      (ctx_ctrl),
    .char_beat     (char_beat),
    .pkt_done      (pkt_done)
  );

  // Stream is held by the controller until pkt_done, so it marks the right entry
  stream_table stream_table_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookup_req    (lookup_req),
    .lookup_stream (lookup_stream),
    .seen          (seen),
    .mask          (mask),
    .mark_seen     (mark_seen),
    .mark_stream   (ctx_ctrl.stream),
    .cfg           (cfg)
  );

  for (genvar c = 0; c < NUM_CAT; c++) begin : g_cat
    dfa_context #(
      .PAT_LEN (PAT_LEN),
      .PATTERN (PATTERNS[c]),
      .CAT     (c)
    ) dfa_context_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .ctx_ctrl  (ctx_ctrl),
      .char_beat (char_beat),
      .count     (match_count[c]),
      .fired     (fired_q[c]),
      .eop_seen  (eop_seen[c])
    );
  end

  // Flags only show in the cycle after the context eop
  assign fired = fired_q & eop_seen;

endmodule

/* rtl/stream_table.sv */
`timescale 1ns/1ps

module stream_table (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        lookup_req,
  input  sess_regex_pkg::stream_id_t  lookup_stream,
  output logic                        seen,
  output sess_regex_pkg::cat_mask_t   mask,
  input  logic                        mark_seen,
  input  sess_regex_pkg::stream_id_t  mark_stream,
  input  sess_regex_pkg::cfg_wr_t     cfg
);

  localparam int NUM_STREAMS = 2 ** $bits(sess_regex_pkg::stream_id_t);

  // Seen bit per stream, never evicted
  logic [NUM_STREAMS-1:0]    seen_vec;

  // Enable mask per stream, zero until configured
  sess_regex_pkg::cat_mask_t mask_mem [NUM_STREAMS];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      seen_vec <= '0;
    else if (mark_seen)
      seen_vec[mark_stream] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_STREAMS; i++)
        mask_mem[i] <= '0;
    end
    else if (cfg.we)
      mask_mem[cfg.stream] <= cfg.mask;
  end

  // Registered read, result valid the cycle after the request
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen <= 1'b0;
      mask <= '0;
    end
    else if (lookup_req)
    begin
      seen <= seen_vec[lookup_stream];
      mask <= mask_mem[lookup_stream];
    end
  end

endmodule

/* sess_regex_scan.f */
+incdir+test
rtl/sess_regex_pkg.sv
rtl/literal_dfa.sv
rtl/dfa_context.sv
rtl/stream_table.sv
rtl/scan_ctrl.sv
rtl/sess_regex_scan_top.sv
test/tb_sess_regex_scan.sv

/* test/tb_scan_checks.svh */
// Literal per category, same order as the DUT's category index
string pat_str [2] = '{"HELO", "RCPT"};

// Reference state, matched prefix length per category and stream
int                           mdl_state [2][64];
bit                           mdl_seen [64];
logic [1:0]                   mdl_mask [64];

// Expected result of the packet in flight
logic [1:0]                   exp_fired;
sess_regex_pkg::count_t [1:0] exp_count;

// Longest k up to max_k where the tail of hist spells the head of pat
function automatic int suffix_prefix(input string hist, input string pat, input int max_k);
  int n;
  int best;
  n    = hist.len();
  best = 0;
  for (int k = 1; k <= max_k; k++)
  begin
    if (k <= n && hist.substr(n - k, n - 1) == pat.substr(0, k - 1))
      best = k;
  end
  return best;
endfunction

// Apply one character on top of a matched prefix
function automatic int step_char(input int cat, input int len, input byte c, output bit hit);
  string hist;
  string pat;
  int    nxt;
  pat  = pat_str[cat];
  hist = {pat.substr(0, len - 1), "."};
  hist.putc(len, c);
  nxt  = suffix_prefix(hist, pat, pat.len());
  hit  = (nxt == pat.len());
  // After a hit only the proper border of the literal carries over
  if (hit)
    nxt = suffix_prefix(pat, pat, pat.len() - 1);
  return nxt;
endfunction

function automatic void model_reset();
  for (int s = 0; s < 64; s++)
  begin
    mdl_seen[s]     = 1'b0;
    mdl_mask[s]     = 2'b00;
    mdl_state[0][s] = 0;
    mdl_state[1][s] = 0;
  end
  exp_fired = '0;
  exp_count = '0;
endfunction

// Expected fired and counts once this packet is done
function automatic void predict_pkt(input int stream, input string text);
  int st;
  bit hit;
  bit any;
  for (int c = 0; c < 2; c++)
  begin
    // A new stream starts from scratch
    st  = mdl_seen[stream] ? mdl_state[c][stream] : 0;
    any = 1'b0;
    if (mdl_mask[stream][c])
    begin
      for (int i = 0; i < text.len(); i++)
      begin
        st  = step_char(c, st, text[i], hit);
        any = any | hit;
      end
      exp_count[c] = exp_count[c] + sess_regex_pkg::count_t'(any);
    end
    // Disabled category leaves its saved state alone
    exp_fired[c]         = any;
    mdl_state[c][stream] = st;
  end
  mdl_seen[stream] = 1'b1;
endfunction

a_fired_ok : assert property (
  @(posedge clk) disable iff (!rst_n) pkt_done |-> fired == exp_fired
) else begin
  n_err++;
  $display("ERR %0t: fired %b, expected %b", $time, $sampled(fired), exp_fired);
end

a_count_ok : assert property (
  @(posedge clk) disable iff (!rst_n) pkt_done |-> match_count == exp_count
) else begin
  n_err++;
  $display("ERR %0t: counts %0d/%0d, expected %0d/%0d", $time, $sampled(match_count[1]),
           $sampled(match_count[0]), exp_count[1], exp_count[0]);
end

// Done is a single-cycle pulse
a_done_pulse : assert property (
  @(posedge clk) disable iff (!rst_n) pkt_done |=> !pkt_done
) else begin
  n_err++;
  $display("ERR %0t: pkt_done held for more than one cycle", $time);
end

// Done follows the input eop by six cycles
a_done_latency : assert property (
  @(posedge clk) disable iff (!rst_n) pkt_done |-> $past(pkt_in.vld && pkt_in.eop, 6)
) else begin
  n_err++;
  $display("ERR %0t: pkt_done not six cycles after the input eop", $time);
end

a_reset_clear : assert property (
  @(posedge clk) !rst_n |=> !pkt_done && fired == '0 && match_count == '0
) else begin
  n_err++;
  $display("ERR %0t: outputs not cleared by reset", $time);
end

/* test/tb_sess_regex_scan.sv */
`timescale 1ns/1ps

module tb_sess_regex_scan;

  localparam int N_RAND     = 40;
  localparam int N_DIRECTED = 16;
  localparam int MAX_LEN    = 12;
  // Worst packet: characters, drain to done, a mask write and an idle gap
  localparam int PKT_CYCLES  = MAX_LEN + 12;
  localparam int CYCLE_LIMIT = (N_RAND + N_DIRECTED) * PKT_CYCLES + 200;

  logic                         clk;
  logic                         rst_n;
  sess_regex_pkg::pkt_in_t      pkt_in;
  sess_regex_pkg::cfg_wr_t      cfg;
  sess_regex_pkg::count_t [1:0] match_count;
  logic                         pkt_done;
  logic [1:0]                   fired;

  int    n_err  = 0;
  int    n_pkts = 0;
  int    cycles = 0;
  // Pattern letters dominate
  string alphabet = "HELOHERCPTRX .";

  `include "tb_scan_checks.svh"

  sess_regex_scan_top #(
    .NUM_CAT (2),
    .PAT_LEN (4)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pkt_in      (pkt_in),
    .cfg         (cfg),
    .match_count (match_count),
    .pkt_done    (pkt_done),
    .fired       (fired)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Run stopped after %0d cycles, a packet never completed", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic write_mask(input int stream, input logic [1:0] mask);
    cfg.we     = 1'b1;
    cfg.stream = 6'(stream);
    cfg.mask   = {6'b0, mask};
    @(posedge clk);
    #1;
    cfg = '0;
    mdl_mask[stream] = mask;
  endtask

  // One character per cycle, eop on the last one, then wait for done
  task automatic send_pkt(input int stream, input string text);
    for (int i = 0; i < text.len(); i++)
    begin
      pkt_in.sop    = (i == 0);
      pkt_in.eop    = (i == text.len() - 1);
      pkt_in.vld    = 1'b1;
      pkt_in.ch     = text[i];
      // Stream id only counts on the sop cycle
      pkt_in.stream = (i == 0) ? 6'(stream) : 6'($urandom);
      @(posedge clk);
      #1;
    end
    pkt_in = '0;
    predict_pkt(stream, text);
    while (!pkt_done)
    begin
      @(posedge clk);
      #1;
    end
    n_pkts++;
    // Checks fire on this edge, and the spacing rule is met after it
    @(posedge clk);
    #1;
  endtask

  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    model_reset();
  endtask

  task automatic report_test(input string name, input int err_mark);
    if (n_err == err_mark)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d error(s)", name, n_err - err_mark);
  endtask

  function automatic string rand_char();
    int k;
    k = $urandom_range(0, alphabet.len() - 1);
    return alphabet.substr(k, k);
  endfunction

  initial
  begin
    int    err_mark;
    int    stream;
    int    len;
    string txt;
    void'($urandom(32'h33d8));
    pkt_in = '0;
    cfg    = '0;
    model_reset();
    reset_dut();

    err_mark = n_err;
    write_mask(1, 2'b01);
    send_pkt(1, "MAIL HELO X");
    report_test("1 whole match", err_mark);

    err_mark = n_err;
    write_mask(5, 2'b11);
    send_pkt(5, "XHE");
    send_pkt(5, "LO");
    report_test("2 split match", err_mark);

    // Stream 5 left holding HE, stream 9 must not see it
    err_mark = n_err;
    write_mask(9, 2'b11);
    send_pkt(5, "RCHE");
    send_pkt(9, "LO");
    report_test("3 separate streams", err_mark);

    err_mark = n_err;
    write_mask(12, 2'b11);
    send_pkt(12, "HE");
    write_mask(12, 2'b10);
    send_pkt(12, "LO");
    write_mask(12, 2'b11);
    send_pkt(12, "LO");
    report_test("4 disabled category", err_mark);

    // Overlap and fallback first, then random traffic
    err_mark = n_err;
    write_mask(20, 2'b11);
    send_pkt(20, "HEHELORCRCPT");
    for (int p = 0; p < N_RAND; p++)
    begin
      stream = $urandom_range(0, 7);
      if ($urandom_range(0, 2) == 0)
        write_mask(stream, 2'($urandom_range(0, 3)));
      len = $urandom_range(1, MAX_LEN);
      txt = "";
      for (int i = 0; i < len; i++)
        txt = {txt, rand_char()};
      send_pkt(stream, txt);
      repeat ($urandom_range(0, 3))
      begin
        @(posedge clk);
        #1;
      end
    end
    report_test("5 random traffic", err_mark);

    // Stream 3 holds HE before reset and must start fresh after it
    err_mark = n_err;
    write_mask(3, 2'b01);
    send_pkt(3, "HE");
    reset_dut();
    write_mask(3, 2'b01);
    send_pkt(3, "LO");
    report_test("6 reset", err_mark);

    $display("%0d packets checked, %0d errors", n_pkts, n_err);
    if (n_err == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
